/* egress_reader.sv */
// Read side of the ingress buffer: polls the ports round-robin for stored packets
// and streams each one onto the output bus through a two-stage pipeline
`timescale 1ns/1ps

module egress_reader
    import router_cfg_pkg::*;
    import ingress_types_pkg::*;
#(
    parameter int  NUM_PORTS         = 4,
    parameter int  DEPTH_PER_PORT    = 64,
    parameter int  NUM_DESC_PER_PORT = 8,
    localparam int PSEL_W            = $clog2(NUM_PORTS),
    localparam int PTR_W             = $clog2(DEPTH_PER_PORT),
    localparam int DPTR_W            = $clog2(NUM_DESC_PER_PORT),
    localparam int WADDR_W           = PSEL_W + PTR_W,
    localparam int DADDR_W           = PSEL_W + DPTR_W
)(
    input  logic                              ing_bus,
    input  logic                              arst_n,
    input  logic [NUM_PORTS-1:0][DPTR_W-1:0]  desc_wr_ptr,
    output logic [DADDR_W-1:0]                desc_rd_addr,
    input  desc_t                             desc_rd_data,
    output logic [WADDR_W-1:0]                word_rd_addr,
    input  logic [DATA_BYTES*8-1:0]           word_rd_data,
    output logic [NUM_PORTS-1:0][PTR_W-1:0]   word_rd_ptr,
    output out_beat_t                         out_beat,
    input  logic                              out_ready
);

    localparam int WCNT_W = LEN_W - BYTES_LOG + 1;

    typedef enum logic [1:0] {
        POLL,
        DESC,
        READ
    } rd_state_t;

    // First pipeline stage, its data word sits in the word store's read register
    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [DATA_BYTES-1:0] keep;
        ing_meta_t             meta;
    } rd_stage_t;

    rd_state_t             state;
    logic [PSEL_W-1:0]     sel;
    logic [PSEL_W-1:0]     next_sel;
    logic [DPTR_W-1:0]     dptr [NUM_PORTS];
    logic [WCNT_W-1:0]     words_left;
    logic [LEN_W-1:0]      cur_len;
    logic [WADDR_W-1:0]    next_addr;
    logic [WADDR_W-1:0]    last_addr;
    logic [DATA_BYTES-1:0] keep_last;
    rd_stage_t             p0;
    logic                  p1_load;
    logic                  p0_load;
    logic                  issue;
    logic                  last_word;

    assign p1_load   = out_ready || !out_beat.valid;
    assign p0_load   = p1_load || !p0.valid;
    assign issue     = (state == READ) && p0_load;
    assign last_word = words_left == WCNT_W'(1);
    assign next_sel  = (sel == PSEL_W'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
    assign next_addr = {sel, word_rd_ptr[sel]};

    // Hold the last issued address so a stalled word stays in the read register
    assign word_rd_addr = issue ? next_addr : last_addr;
    assign desc_rd_addr = {sel, dptr[sel]};

    always_comb begin
        keep_last = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (i < int'(cur_len[BYTES_LOG-1:0])) begin
                keep_last[i] = 1'b1;
            end
        end
        if (cur_len[BYTES_LOG-1:0] == '0) begin
            keep_last = '1;
        end
    end

    //////////////////////////////
    // Poll/read FSM and output pipeline

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            state       <= POLL;
            sel         <= '0;
            dptr        <= '{default: '0};
            word_rd_ptr <= '0;
            words_left  <= '0;
            p0          <= '0;
            out_beat    <= '0;
        end else begin
            if (p1_load) begin
                out_beat.valid <= p0.valid;
                if (p0.valid) begin
                    out_beat.data <= word_rd_data;
                    out_beat.keep <= p0.keep;
                    out_beat.last <= p0.last;
                    out_beat.meta <= p0.meta;
                end
            end

            if (p0_load) begin
                p0.valid <= issue;
            end
            if (issue) begin
                p0.last              <= last_word;
                p0.keep              <= last_word ? keep_last : '1;
                p0.meta.ingress_port <= PORT_W'(sel);
                p0.meta.byte_length  <= cur_len;
            end

            case (state)
                POLL: begin
                    if (dptr[sel] != desc_wr_ptr[sel]) begin
                        state <= DESC;
                    end else begin
                        sel <= next_sel;
                    end
                end
                DESC: begin
                    // Word count is the byte length rounded up to whole words
                    words_left <= WCNT_W'((int'(desc_rd_data.byte_length) + DATA_BYTES - 1)
                                          / DATA_BYTES);
                    state      <= READ;
                end
                READ: begin
                    if (issue) begin
                        word_rd_ptr[sel] <= word_rd_ptr[sel] + 1'b1;
                        words_left       <= words_left - 1'b1;
                        if (last_word) begin
                            dptr[sel] <= dptr[sel] + 1'b1;
                            sel       <= next_sel;
                            state     <= POLL;
                        end
                    end
                end
                default: begin
                    state <= POLL;
                end
            endcase
        end
    end

    always_ff @(posedge ing_bus) begin
        if (state == DESC) begin
            cur_len <= desc_rd_data.byte_length;
        end
        if (issue) begin
            last_addr <= next_addr;
        end
    end

endmodule

/* ingress_buffer_top.sv */
// Ingress buffer top level: writer, word and descriptor stores, and egress reader
// Sizes are set here and passed down to every block
`timescale 1ns/1ps

module ingress_buffer_top
    import router_cfg_pkg::*;
    import ingress_types_pkg::*;
#(
    parameter int NUM_PORTS         = 4,
    parameter int DEPTH_PER_PORT    = 64,
    parameter int NUM_DESC_PER_PORT = 8
)(
    input  logic                     ing_bus,
    input  logic                     arst_n,
    input  in_beat_t [NUM_PORTS-1:0] in_ports,
    output logic [NUM_PORTS-1:0]     in_ready,
    output out_beat_t                out_beat,
    input  logic                     out_ready,
    output logic [NUM_PORTS-1:0]     overflow
);

    localparam int PSEL_W  = $clog2(NUM_PORTS);
    localparam int PTR_W   = $clog2(DEPTH_PER_PORT);
    localparam int DPTR_W  = $clog2(NUM_DESC_PER_PORT);
    localparam int WADDR_W = PSEL_W + PTR_W;
    localparam int DADDR_W = PSEL_W + DPTR_W;

    typedef logic [DATA_BYTES*8-1:0] word_t;

    logic                             word_wr_en;
    logic [WADDR_W-1:0]               word_wr_addr;
    word_t                            word_wr_data;
    logic [WADDR_W-1:0]               word_rd_addr;
    word_t                            word_rd_data;
    logic [NUM_PORTS-1:0][PTR_W-1:0]  word_rd_ptr;

    logic                             desc_wr_en;
    logic [DADDR_W-1:0]               desc_wr_addr;
    desc_t                            desc_wr_data;
    logic [DADDR_W-1:0]               desc_rd_addr;
    desc_t                            desc_rd_data;
    logic [NUM_PORTS-1:0][DPTR_W-1:0] desc_wr_ptr;

    ingress_writer #(
        .NUM_PORTS         (NUM_PORTS),
        .DEPTH_PER_PORT    (DEPTH_PER_PORT),
        .NUM_DESC_PER_PORT (NUM_DESC_PER_PORT)
    ) u_writer (
        .ing_bus      (ing_bus),
        .arst_n       (arst_n),
        .in_ports     (in_ports),
        .in_ready     (in_ready),
        .word_rd_ptr  (word_rd_ptr),
        .word_wr_en   (word_wr_en),
        .word_wr_addr (word_wr_addr),
        .word_wr_data (word_wr_data),
        .desc_wr_en   (desc_wr_en),
        .desc_wr_addr (desc_wr_addr),
        .desc_wr_data (desc_wr_data),
        .desc_wr_ptr  (desc_wr_ptr),
        .overflow     (overflow)
    );

    // Packet words, one partition per port
    partition_ram #(
        .payload_t (word_t),
        .DEPTH     (NUM_PORTS * DEPTH_PER_PORT)
    ) word_store (
        .ing_bus (ing_bus),
        .wr_en   (word_wr_en),
        .wr_addr (word_wr_addr),
        .wr_data (word_wr_data),
        .rd_addr (word_rd_addr),
        .rd_data (word_rd_data)
    );

    // Byte lengths of complete packets
    partition_ram #(
        .payload_t (desc_t),
        .DEPTH     (NUM_PORTS * NUM_DESC_PER_PORT)
    ) desc_store (
        .ing_bus (ing_bus),
        .wr_en   (desc_wr_en),
        .wr_addr (desc_wr_addr),
        .wr_data (desc_wr_data),
        .rd_addr (desc_rd_addr),
        .rd_data (desc_rd_data)
    );

    egress_reader #(
        .NUM_PORTS         (NUM_PORTS),
        .DEPTH_PER_PORT    (DEPTH_PER_PORT),
        .NUM_DESC_PER_PORT (NUM_DESC_PER_PORT)
    ) u_reader (
        .ing_bus      (ing_bus),
        .arst_n       (arst_n),
        .desc_wr_ptr  (desc_wr_ptr),
        .desc_rd_addr (desc_rd_addr),
        .desc_rd_data (desc_rd_data),
        .word_rd_addr (word_rd_addr),
        .word_rd_data (word_rd_data),
        .word_rd_ptr  (word_rd_ptr),
        .out_beat     (out_beat),
        .out_ready    (out_ready)
    );

endmodule

/* ingress_types_pkg.sv */
// Struct types for input words, packet descriptors and output beats
// Imported by the buffer modules and the testbench
package ingress_types_pkg;
    import router_cfg_pkg::*;

    //////////////////////////////
    // Ingress side

    // One word offered by an ingress port
    typedef struct packed {
        logic                    valid;
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } in_beat_t;

    // One stored packet, kept per port in the descriptor store
    typedef struct packed {
        logic [LEN_W-1:0] byte_length;
    } desc_t;

    //////////////////////////////
    // Egress side

    typedef struct packed {
        logic [PORT_W-1:0] ingress_port;
        logic [LEN_W-1:0]  byte_length;
    } ing_meta_t;

    typedef struct packed {
        logic                    valid;
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
        ing_meta_t               meta;
    } out_beat_t;

endpackage

/* ingress_writer.sv */
// Write side of the ingress buffer: round-robin slot over the ports, one word per cycle
// Drops packets whole when the port's partition or descriptor area runs full
`timescale 1ns/1ps

module ingress_writer
    import router_cfg_pkg::*;
    import ingress_types_pkg::*;
#(
    parameter int  NUM_PORTS         = 4,
    parameter int  DEPTH_PER_PORT    = 64,
    parameter int  NUM_DESC_PER_PORT = 8,
    localparam int PSEL_W            = $clog2(NUM_PORTS),
    localparam int PTR_W             = $clog2(DEPTH_PER_PORT),
    localparam int DPTR_W            = $clog2(NUM_DESC_PER_PORT),
    localparam int WADDR_W           = PSEL_W + PTR_W,
    localparam int DADDR_W           = PSEL_W + DPTR_W
)(
    input  logic                              ing_bus,
    input  logic                              arst_n,
    input  in_beat_t [NUM_PORTS-1:0]          in_ports,
    output logic [NUM_PORTS-1:0]              in_ready,
    input  logic [NUM_PORTS-1:0][PTR_W-1:0]   word_rd_ptr,
    output logic                              word_wr_en,
    output logic [WADDR_W-1:0]                word_wr_addr,
    output logic [DATA_BYTES*8-1:0]           word_wr_data,
    output logic                              desc_wr_en,
    output logic [DADDR_W-1:0]                desc_wr_addr,
    output desc_t                             desc_wr_data,
    output logic [NUM_PORTS-1:0][DPTR_W-1:0]  desc_wr_ptr,
    output logic [NUM_PORTS-1:0]              overflow
);

    localparam int WIDX_W = LEN_W - BYTES_LOG;

    // Word accepted in the previous cycle
    typedef struct packed {
        logic               valid;
        logic               last;
        logic [PSEL_W-1:0]  port;
        logic [WIDX_W-1:0]  widx;
        logic [BYTES_LOG:0] nbytes;
    } wr_stage_t;

    // Input keep is contiguous, so counting ones gives the byte count
    function automatic logic [BYTES_LOG:0] keep_bytes(input logic [DATA_BYTES-1:0] keep);
        logic [BYTES_LOG:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n = n + {{BYTES_LOG{1'b0}}, keep[i]};
        end
        return n;
    endfunction

    logic [PSEL_W-1:0]       slot;
    in_beat_t                cur;
    wr_stage_t               s1;
    logic [DATA_BYTES*8-1:0] s1_data;

    logic [PTR_W-1:0]        wr_ptr   [NUM_PORTS];
    logic [PTR_W-1:0]        wr_cmt   [NUM_PORTS];
    logic [DPTR_W-1:0]       desc_cnt [NUM_PORTS];
    logic [WIDX_W-1:0]       wcnt     [NUM_PORTS];
    logic [NUM_PORTS-1:0]    drop;
    logic [NUM_PORTS-1:0]    drained;

    logic                    part_full;
    logic                    desc_full;
    logic                    desc_pend;
    logic [PSEL_W-1:0]       pend_port;
    logic [LEN_W-1:0]        pend_len;
    logic [PSEL_W-1:0]       desc_port;

    assign cur = in_ports[slot];

    always_comb begin
        in_ready       = '0;
        in_ready[slot] = 1'b1;
    end

    // Every committed word has been read, so no descriptor is outstanding
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_drain
        assign drained[i] = word_rd_ptr[i] == wr_cmt[i];
    end

    assign part_full = PTR_W'(wr_ptr[s1.port] + 1'b1) == word_rd_ptr[s1.port];
    assign desc_full = !drained[s1.port] &&
                       desc_cnt[s1.port] == DPTR_W'(NUM_DESC_PER_PORT - 1);

    //////////////////////////////
    // Slot, pointers and drop control

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            slot        <= '0;
            s1          <= '0;
            wr_ptr      <= '{default: '0};
            wr_cmt      <= '{default: '0};
            desc_cnt    <= '{default: '0};
            wcnt        <= '{default: '0};
            drop        <= '0;
            word_wr_en  <= 1'b0;
            desc_pend   <= 1'b0;
            desc_wr_en  <= 1'b0;
            desc_wr_ptr <= '0;
            overflow    <= '0;
        end else begin
            slot <= (slot == PSEL_W'(NUM_PORTS - 1)) ? '0 : slot + 1'b1;

            // Stage 0: capture the slot's word
            s1.valid  <= cur.valid;
            s1.last   <= cur.last;
            s1.port   <= slot;
            s1.widx   <= wcnt[slot];
            s1.nbytes <= keep_bytes(cur.keep);
            if (cur.valid) begin
                wcnt[slot] <= cur.last ? '0 : wcnt[slot] + 1'b1;
            end

            for (int i = 0; i < NUM_PORTS; i++) begin
                if (drained[i]) begin
                    desc_cnt[i] <= '0;
                end
            end

            // Stage 1: store, commit or drop
            word_wr_en <= 1'b0;
            desc_pend  <= 1'b0;
            overflow   <= '0;
            if (s1.valid) begin
                if (drop[s1.port] || part_full || desc_full) begin
                    // Rewind to the last good packet, stay in drop until the last word
                    drop[s1.port]     <= !s1.last;
                    wr_ptr[s1.port]   <= wr_cmt[s1.port];
                    overflow[s1.port] <= s1.last;
                end else begin
                    word_wr_en      <= 1'b1;
                    wr_ptr[s1.port] <= wr_ptr[s1.port] + 1'b1;
                    if (s1.last) begin
                        desc_pend       <= 1'b1;
                        wr_cmt[s1.port] <= wr_ptr[s1.port] + 1'b1;
                        desc_cnt[s1.port] <= drained[s1.port] ? DPTR_W'(1)
                                                              : desc_cnt[s1.port] + 1'b1;
                    end
                end
            end

            // Stage 2: descriptor write, pointer moves as it lands
            desc_wr_en <= desc_pend;
            if (desc_wr_en) begin
                desc_wr_ptr[desc_port] <= desc_wr_ptr[desc_port] + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Payload path

    always_ff @(posedge ing_bus) begin
        s1_data      <= cur.data;
        word_wr_addr <= {s1.port, wr_ptr[s1.port]};
        word_wr_data <= s1_data;
        pend_port    <= s1.port;
        pend_len     <= {s1.widx, {BYTES_LOG{1'b0}}} + LEN_W'(s1.nbytes);
        desc_port    <= pend_port;
        desc_wr_addr <= {pend_port, desc_wr_ptr[pend_port]};
        desc_wr_data.byte_length <= pend_len;
    end

endmodule

/* partition_ram.sv */
// Simple dual-port memory with registered read, one write and one read port
// Holds one partition per ingress port, the port number forms the upper address bits
`timescale 1ns/1ps

module partition_ram #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 64,
    localparam int ADDR_W    = $clog2(DEPTH)
)(
    input  logic              ing_bus,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  payload_t          wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output payload_t          rd_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge ing_bus) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data lands one cycle after the address
    always_ff @(posedge ing_bus) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* router_cfg_pkg.sv */
// Bus and packet size constants shared by the ingress buffer and its testbench
package router_cfg_pkg;

    // Output and input bus word
    localparam int DATA_BYTES = 8;
    localparam int BYTES_LOG  = $clog2(DATA_BYTES);

    // Largest packet and the width of a byte length that can hold it
    localparam int MTU_BYTES  = 1500;
    localparam int LEN_W      = $clog2(MTU_BYTES + 1);

    // Port numbering as carried in the output metadata
    localparam int MAX_PORTS  = 8;
    localparam int PORT_W     = $clog2(MAX_PORTS);

endpackage

/* run.sh */
#!/bin/sh
# Build the ingress buffer testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ingress_buffer -f src.f -o tb_ingress_buffer
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_ingress_buffer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* src.f */
router_cfg_pkg.sv
ingress_types_pkg.sv
partition_ram.sv
ingress_writer.sv
egress_reader.sv
ingress_buffer_top.sv
tb_ingress_buffer.sv

/* tb_ingress_buffer.sv */
// Testbench for the ingress buffer: random packets on every port, random output stalls
// A scoreboard of per-port packet queues is checked by immediate assertions
`timescale 1ns/1ps

module tb_ingress_buffer
    import router_cfg_pkg::*;
    import ingress_types_pkg::*;
();

    localparam int NUM_PORTS      = 4;
    localparam int PKTS           = 40;
    localparam int MAX_LEN        = 200;
    localparam int MAX_WORDS      = (MAX_LEN + DATA_BYTES - 1) / DATA_BYTES;
    localparam int STALL_START    = 600;
    localparam int STALL_CYCLES   = 400;
    localparam int TIMEOUT_CYCLES = PKTS * NUM_PORTS * 30 + 2000;

    logic                     ing_bus;
    logic                     arst_n;
    in_beat_t [NUM_PORTS-1:0] in_ports;
    logic [NUM_PORTS-1:0]     in_ready;
    out_beat_t                out_beat;
    logic                     out_ready;
    logic [NUM_PORTS-1:0]     overflow;

    // Stimulus store, filled once before reset is released
    int                      pkt_len  [NUM_PORTS][PKTS];
    logic [DATA_BYTES*8-1:0] pkt_data [NUM_PORTS][PKTS][MAX_WORDS];

    // Per-port sender state and the scoreboard
    int                   pkt_cnt  [NUM_PORTS];
    int                   word_idx [NUM_PORTS];
    logic [NUM_PORTS-1:0] took;
    int                   exp_q    [NUM_PORTS][$];
    int                   rx_word;
    int                   rx_port;
    logic                 stall_prev;
    out_beat_t            beat_prev;
    int                   cycle;

    ingress_buffer_top #(
        .NUM_PORTS      (NUM_PORTS),
        .DEPTH_PER_PORT (64)
    ) UUT (
        .ing_bus   (ing_bus),
        .arst_n    (arst_n),
        .in_ports  (in_ports),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_ready (out_ready),
        .overflow  (overflow)
    );

    initial ing_bus = 1'b0;
    always #2 ing_bus = ~ing_bus;

    //////////////////////////////
    // Helpers

    function automatic int word_count(input int len);
        return (len + DATA_BYTES - 1) / DATA_BYTES;
    endfunction

    // Last word carries len mod 8 bytes from byte 0, a full word when that is zero
    function automatic logic [DATA_BYTES-1:0] last_keep(input int len);
        int n;
        n = len % DATA_BYTES;
        return (n == 0) ? '1 : DATA_BYTES'((1 << n) - 1);
    endfunction

    function automatic logic [DATA_BYTES*8-1:0] keep_mask(input logic [DATA_BYTES-1:0] keep);
        logic [DATA_BYTES*8-1:0] m;
        for (int i = 0; i < DATA_BYTES; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    function automatic in_beat_t make_beat(input int p, input int i, input int w);
        in_beat_t b;
        b.valid = 1'b1;
        b.data  = pkt_data[p][i][w];
        b.last  = (w == word_count(pkt_len[p][i]) - 1);
        b.keep  = b.last ? last_keep(pkt_len[p][i]) : '1;
        return b;
    endfunction

    function automatic bit queues_empty();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic bit sent_all();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (pkt_cnt[p] != PKTS) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        $display("*** FAILED ***");
        $display("ERR time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("*** FAILED ***");
        $display("Error at time %0t: %s", $time, why);
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        assert (got === exp) else value_error(name, got, exp);
    endtask

    //////////////////////////////
    // Reset, stimulus setup and end of run

    initial begin
        in_ports  = '0;
        out_ready = 1'b0;
        arst_n    = 1'b0;
        took      = '0;
        rx_word   = 0;
        rx_port   = 0;
        cycle     = 0;
        stall_prev = 1'b0;
        beat_prev  = '0;
        void'($urandom(32'hcda0));
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkt_cnt[p]  = 0;
            word_idx[p] = 0;
            for (int i = 0; i < PKTS; i++) begin
                pkt_len[p][i] = 1 + int'($urandom % MAX_LEN);
                for (int w = 0; w < MAX_WORDS; w++) begin
                    pkt_data[p][i][w] = {$urandom, $urandom};
                end
            end
        end

        repeat (5) @(posedge ing_bus);
        #0.5;
        compare_value("out_beat.valid", out_beat.valid, 1'b0);
        compare_value("overflow", overflow, '0);
        compare_value("in_ready", in_ready, 1);
        arst_n = 1'b1;

        // Sample well after the edge, when the monitor has settled
        while (!(sent_all() && queues_empty())) begin
            @(posedge ing_bus);
            #1;
        end
        // A few more cycles so a stray beat or overflow pulse is still caught
        repeat (20) @(posedge ing_bus);
        #1;
        $display("*** PASSED ***");
        $finish;
    end

    always @(posedge ing_bus) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            abort_run("timeout, not every packet was delivered or dropped in time");
        end
    end

    //////////////////////////////
    // Input and output drivers

    always @(posedge ing_bus) begin : drive
        logic go;
        go = arst_n;
        #0.5;
        if (go) begin
            if (cycle >= STALL_START && cycle < STALL_START + STALL_CYCLES) begin
                out_ready = 1'b0;
            end else begin
                out_ready = ($urandom % 4) != 0;
            end
            // A word once offered is held until the port's slot takes it
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!in_ports[p].valid || took[p]) begin
                    if (pkt_cnt[p] < PKTS && ($urandom % 2) == 0) begin
                        in_ports[p] = make_beat(p, pkt_cnt[p], word_idx[p]);
                    end else begin
                        in_ports[p] = '0;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Monitor and scoreboard

    always @(posedge ing_bus) begin : monitor
        int port;
        int idx;
        int len;
        int nw;
        logic [DATA_BYTES-1:0] exp_keep;
        logic [DATA_BYTES*8-1:0] mask;
        if (arst_n) begin
            // A stalled beat must not move
            if (stall_prev) begin
                compare_value("out_beat", out_beat, beat_prev);
            end
            stall_prev = out_beat.valid && !out_ready;
            beat_prev  = out_beat;

            for (int p = 0; p < NUM_PORTS; p++) begin
                if (overflow[p]) begin
                    assert (exp_q[p].size() > 0)
                        else abort_run("overflow pulse on a port with no packet queued");
                    // The dropped packet is the newest one the port finished
                    void'(exp_q[p].pop_back());
                end
            end

            for (int p = 0; p < NUM_PORTS; p++) begin
                took[p] = in_ready[p] && in_ports[p].valid;
                if (took[p]) begin
                    if (in_ports[p].last) begin
                        exp_q[p].push_back(pkt_cnt[p]);
                        pkt_cnt[p]  = pkt_cnt[p] + 1;
                        word_idx[p] = 0;
                    end else begin
                        word_idx[p] = word_idx[p] + 1;
                    end
                end
            end

            if (out_beat.valid && out_ready) begin
                port = int'(out_beat.meta.ingress_port);
                assert (port < NUM_PORTS) else abort_run("output beat names a missing port");
                if (rx_word > 0) begin
                    compare_value("out_beat.meta.ingress_port", port, rx_port);
                end
                assert (exp_q[port].size() > 0)
                    else abort_run("output beat from a port with no packet queued");
                idx      = exp_q[port][0];
                len      = pkt_len[port][idx];
                nw       = word_count(len);
                exp_keep = (rx_word == nw - 1) ? last_keep(len) : '1;
                mask     = keep_mask(exp_keep);
                compare_value("out_beat.meta.byte_length", out_beat.meta.byte_length, len);
                compare_value("out_beat.last", out_beat.last, rx_word == nw - 1);
                compare_value("out_beat.keep", out_beat.keep, exp_keep);
                compare_value("out_beat.data", out_beat.data & mask,
                              pkt_data[port][idx][rx_word] & mask);
                if (out_beat.last) begin
                    void'(exp_q[port].pop_front());
                    rx_word = 0;
                end else begin
                    rx_port = port;
                    rx_word = rx_word + 1;
                end
            end
        end
    end

endmodule
